//--- blit_top.f
+incdir+common
common/blit_pkg.sv
hw/blit_rect_walk.sv
hw/blit_addr_calc.sv
hw/blit_pixel_fetch.sv
hw/blit_colour_resolve.sv
hw/blit_top.sv
tb/blit_tb.sv

//--- common/blit_defines.svh
`ifndef BLIT_DEFINES_SVH
`define BLIT_DEFINES_SVH

// coordinates, sizes and signed scales
`define BLIT_COORD_W 16

// byte addresses on the read bus
`define BLIT_ADDR_W 32

// AXI-lite read data word
`define BLIT_DATA_W 32

// colour value and extracted pixel field
`define BLIT_COLOUR_W 16

// palette address port
`define BLIT_PAL_AW 16

`endif

//--- common/blit_pkg.sv
`include "blit_defines.svh"

package blit_pkg;

    typedef logic [`BLIT_COORD_W-1:0] coord_t;     // screen or sheet position
    typedef logic [`BLIT_ADDR_W-1:0] addr_t;       // byte address
    typedef logic [`BLIT_COLOUR_W-1:0] colour_t;   // colour or palette index

    // scaling kind of one axis
    typedef enum logic {
        SCALE_UP,      // repeat each source pixel
        SCALE_DOWN     // skip source pixels
    } scale_mode_t;

    // bits per pixel in the sheet
    typedef enum logic [4:0] {
        CT_1  = 5'd1,
        CT_2  = 5'd2,
        CT_4  = 5'd4,
        CT_8  = 5'd8,
        CT_16 = 5'd16  // direct colour, no palette
    } ct_depth_t;

endpackage

//--- hw/blit_addr_calc.sv
`timescale 1ns/100ps
`include "blit_defines.svh"

module blit_addr_calc import blit_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      pix_valid,
    output logic      pix_ready,
    input  coord_t    sheet_x,
    input  coord_t    sheet_y,
    input  coord_t    screen_x,
    input  coord_t    screen_y,
    input  addr_t     sheet_base,
    input  coord_t    sheet_width,
    input  ct_depth_t depth,
    output logic      adr_valid,
    input  logic      adr_ready,
    output addr_t     word_addr,
    output logic [4:0] bit_off,
    output coord_t    out_x,
    output coord_t    out_y
);

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_FULL,
        ST_BUF_FULL
    } buf_state_t;

    buf_state_t state;

    addr_t pix_idx, bit_pos, word_nxt;
    logic  in_fire, out_fire;

    // parked second entry
    addr_t      buf_addr;
    logic [4:0] buf_off;
    coord_t     buf_x, buf_y;

    assign pix_idx  = addr_t'(sheet_y) * addr_t'(sheet_width) + addr_t'(sheet_x);
    assign bit_pos  = pix_idx * addr_t'(depth);
    assign word_nxt = sheet_base + {3'b000, bit_pos[`BLIT_ADDR_W-1:5], 2'b00};

    assign pix_ready = (state != ST_BUF_FULL);
    assign adr_valid = (state != ST_EMPTY);
    assign in_fire   = pix_valid && pix_ready;
    assign out_fire  = adr_valid && adr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_EMPTY;
        end else begin
            case (state)
                ST_EMPTY: begin
                    if (in_fire) begin
                        state     <= ST_FULL;
                        word_addr <= word_nxt;
                        bit_off   <= bit_pos[4:0];
                        out_x     <= screen_x;
                        out_y     <= screen_y;
                    end
                end
                ST_FULL: begin
                    if (in_fire && !out_fire) begin
                        state    <= ST_BUF_FULL;  // output stalled, park new item
                        buf_addr <= word_nxt;
                        buf_off  <= bit_pos[4:0];
                        buf_x    <= screen_x;
                        buf_y    <= screen_y;
                    end else if (in_fire) begin
                        word_addr <= word_nxt;
                        bit_off   <= bit_pos[4:0];
                        out_x     <= screen_x;
                        out_y     <= screen_y;
                    end else if (out_fire) begin
                        state <= ST_EMPTY;
                    end
                end
                ST_BUF_FULL: begin
                    if (out_fire) begin
                        state     <= ST_FULL;
                        word_addr <= buf_addr;
                        bit_off   <= buf_off;
                        out_x     <= buf_x;
                        out_y     <= buf_y;
                    end
                end
                default: state <= ST_EMPTY;
            endcase
        end
    end

endmodule

//--- hw/blit_colour_resolve.sv
`timescale 1ns/100ps
`include "blit_defines.svh"

module blit_colour_resolve import blit_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fld_valid,
    input  colour_t                 field,
    input  coord_t                  fld_x,
    input  coord_t                  fld_y,
    input  ct_depth_t               depth,
    input  logic [`BLIT_PAL_AW-1:0] pal_base,
    output logic [`BLIT_PAL_AW-1:0] pal_addr,
    input  colour_t                 pal_data,
    output coord_t                  fb_x,
    output coord_t                  fb_y,
    output colour_t                 fb_colour,
    output logic                    fb_write
);

    logic    valid_1;
    colour_t field_1, field_2;
    coord_t  x_1, y_1;
    logic    direct_1, direct_2;  // 16 bpp, palette bypassed

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_1  <= 1'b0;
            fb_write <= 1'b0;
        end else begin
            valid_1  <= fld_valid;
            fb_write <= valid_1;
        end
    end

    always_ff @(posedge clk) begin
        pal_addr <= pal_base + `BLIT_PAL_AW'(field);
        field_1  <= field;
        x_1      <= fld_x;
        y_1      <= fld_y;
        direct_1 <= (depth == CT_16);
        field_2  <= field_1;
        fb_x     <= x_1;
        fb_y     <= y_1;
        direct_2 <= direct_1;
    end

    // palette data arrives together with fb_write
    assign fb_colour = direct_2 ? field_2 : pal_data;

endmodule

//--- hw/blit_pixel_fetch.sv
`timescale 1ns/100ps
`include "blit_defines.svh"

module blit_pixel_fetch import blit_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    adr_valid,
    output logic                    adr_ready,
    input  addr_t                   word_addr,
    input  logic [4:0]              bit_off,
    input  ct_depth_t               depth,
    input  coord_t                  in_x,
    input  coord_t                  in_y,
    output addr_t                   araddr,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [`BLIT_DATA_W-1:0] rdata,
    input  logic                    rvalid,
    output logic                    rready,
    output logic                    fld_valid,
    output colour_t                 field,
    output coord_t                  fld_x,
    output coord_t                  fld_y
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_DONE
    } fetch_state_t;

    fetch_state_t state;

    // kept word from the last read
    logic                    kept_valid;
    addr_t                   kept_addr;
    logic [`BLIT_DATA_W-1:0] kept_word;

    logic [4:0] off_q;
    ct_depth_t  depth_q;
    logic       accept, hit;

    // msb-first packing, so the field sits below bit 31 - off
    function automatic colour_t extract_field(input logic [`BLIT_DATA_W-1:0] word,
                                              input logic [4:0] off,
                                              input ct_depth_t d);
        logic [5:0]              shift;
        logic [`BLIT_DATA_W-1:0] mask;
        logic [`BLIT_DATA_W-1:0] bits;
        shift = 6'd32 - 6'(off) - 6'(d);
        mask  = (`BLIT_DATA_W'(1) << d) - 1'b1;
        bits  = (word >> shift) & mask;
        return bits[`BLIT_COLOUR_W-1:0];
    endfunction

    // done doubles as idle so hits stream one per cycle
    assign adr_ready = (state == ST_IDLE) || (state == ST_DONE);
    assign accept    = adr_valid && adr_ready;
    assign hit       = kept_valid && (kept_addr == word_addr);

    assign arvalid   = (state == ST_ADDR);
    assign rready    = (state == ST_DATA);
    assign fld_valid = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            kept_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (accept) begin
                        fld_x   <= in_x;
                        fld_y   <= in_y;
                        off_q   <= bit_off;
                        depth_q <= depth;
                        if (hit) begin
                            state <= ST_DONE;
                            field <= extract_field(kept_word, bit_off, depth);
                        end else begin
                            state  <= ST_ADDR;
                            araddr <= word_addr;
                        end
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_ADDR: begin
                    if (arready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid) begin
                        state      <= ST_DONE;
                        kept_valid <= 1'b1;
                        kept_addr  <= araddr;
                        kept_word  <= rdata;
                        field      <= extract_field(rdata, off_q, depth_q);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hw/blit_rect_walk.sv
`timescale 1ns/100ps
`include "blit_defines.svh"

module blit_rect_walk import blit_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  coord_t                  start_x,
    input  coord_t                  start_y,
    input  coord_t                  src_x,
    input  coord_t                  src_y,
    input  coord_t                  width,
    input  coord_t                  height,
    input  coord_t                  scale_x,     // signed, negative means downscale
    input  coord_t                  scale_y,
    input  logic                    mirror_x,
    input  logic                    mirror_y,
    input  addr_t                   sheet_base,
    input  coord_t                  sheet_width,
    input  ct_depth_t               depth,
    input  logic [`BLIT_PAL_AW-1:0] pal_base,
    output logic                    pix_valid,
    input  logic                    pix_ready,
    output coord_t                  sheet_x,
    output coord_t                  sheet_y,
    output coord_t                  screen_x,
    output coord_t                  screen_y,
    output addr_t                   cur_sheet_base,
    output coord_t                  cur_sheet_width,
    output ct_depth_t               cur_depth,
    output logic [`BLIT_PAL_AW-1:0] cur_pal_base
);

    typedef enum logic {
        ST_IDLE,
        ST_GEN
    } walk_state_t;

    walk_state_t state;

    scale_mode_t mode_x, mode_y;
    coord_t      mag_x, mag_y;           // scale magnitude
    coord_t      sub_x, sub_y;           // repeat counters for upscale
    coord_t      cnt_i, cnt_j;           // raster position in the rectangle
    coord_t      last_i, last_j;
    coord_t      row_sheet_x;            // sheet x at the start of each row
    coord_t      row_screen_x;           // screen x at the start of each row
    logic        mir_x, mir_y;

    logic   pix_fire;
    logic   x_rep_done, y_rep_done;
    coord_t sheet_x_nxt, sheet_y_nxt;

    assign pix_fire   = pix_valid && pix_ready;
    assign x_rep_done = (sub_x == mag_x - 1'b1);
    assign y_rep_done = (sub_y == mag_y - 1'b1);

    assign sheet_x_nxt = (mode_x == SCALE_DOWN) ? sheet_x + mag_x :
                         (x_rep_done ? sheet_x + 1'b1 : sheet_x);
    assign sheet_y_nxt = (mode_y == SCALE_DOWN) ? sheet_y + mag_y :
                         (y_rep_done ? sheet_y + 1'b1 : sheet_y);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            cmd_ready <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    cmd_ready <= 1'b1;
                    if (cmd_valid && cmd_ready) begin
                        state           <= ST_GEN;
                        cmd_ready       <= 1'b0;
                        pix_valid       <= 1'b1;
                        cur_sheet_base  <= sheet_base;
                        cur_sheet_width <= sheet_width;
                        cur_depth       <= depth;
                        cur_pal_base    <= pal_base;
                        mode_x <= scale_x[`BLIT_COORD_W-1] ? SCALE_DOWN : SCALE_UP;
                        mode_y <= scale_y[`BLIT_COORD_W-1] ? SCALE_DOWN : SCALE_UP;
                        mag_x  <= scale_x[`BLIT_COORD_W-1] ? -scale_x : scale_x;
                        mag_y  <= scale_y[`BLIT_COORD_W-1] ? -scale_y : scale_y;
                        mir_x  <= mirror_x;
                        mir_y  <= mirror_y;
                        last_i <= width - 1'b1;
                        last_j <= height - 1'b1;
                        cnt_i  <= '0;
                        cnt_j  <= '0;
                        sub_x  <= '0;
                        sub_y  <= '0;
                        row_sheet_x  <= src_x;
                        row_screen_x <= mirror_x ? start_x + width - 1'b1 : start_x;
                        sheet_x  <= src_x;
                        sheet_y  <= src_y;
                        screen_x <= mirror_x ? start_x + width - 1'b1 : start_x;
                        screen_y <= mirror_y ? start_y + height - 1'b1 : start_y;
                    end
                end
                ST_GEN: begin
                    if (pix_fire) begin
                        if (cnt_i != last_i) begin
                            cnt_i    <= cnt_i + 1'b1;
                            sub_x    <= x_rep_done ? '0 : sub_x + 1'b1;
                            sheet_x  <= sheet_x_nxt;
                            screen_x <= mir_x ? screen_x - 1'b1 : screen_x + 1'b1;
                        end else if (cnt_j != last_j) begin
                            cnt_i    <= '0;              // row wrap
                            cnt_j    <= cnt_j + 1'b1;
                            sub_x    <= '0;
                            sheet_x  <= row_sheet_x;
                            screen_x <= row_screen_x;
                            sub_y    <= y_rep_done ? '0 : sub_y + 1'b1;
                            sheet_y  <= sheet_y_nxt;
                            screen_y <= mir_y ? screen_y - 1'b1 : screen_y + 1'b1;
                        end else begin
                            state     <= ST_IDLE;        // last pixel gone
                            pix_valid <= 1'b0;
                            cmd_ready <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hw/blit_top.sv
`timescale 1ns/100ps
`include "blit_defines.svh"

module blit_top import blit_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  coord_t                  start_x,
    input  coord_t                  start_y,
    input  coord_t                  src_x,
    input  coord_t                  src_y,
    input  coord_t                  width,
    input  coord_t                  height,
    input  coord_t                  scale_x,
    input  coord_t                  scale_y,
    input  logic                    mirror_x,
    input  logic                    mirror_y,
    input  addr_t                   sheet_base,
    input  coord_t                  sheet_width,
    input  ct_depth_t               depth,
    input  logic [`BLIT_PAL_AW-1:0] pal_base,
    output addr_t                   araddr,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [`BLIT_DATA_W-1:0] rdata,
    input  logic                    rvalid,
    output logic                    rready,
    output logic [`BLIT_PAL_AW-1:0] pal_addr,
    input  colour_t                 pal_data,
    output coord_t                  fb_x,
    output coord_t                  fb_y,
    output colour_t                 fb_colour,
    output logic                    fb_write
);

    // walker to address stage
    logic   pix_valid, pix_ready;
    coord_t sheet_x, sheet_y, screen_x, screen_y;

    // per-command constants held by the walker
    addr_t                   cur_sheet_base;
    coord_t                  cur_sheet_width;
    ct_depth_t               cur_depth;
    logic [`BLIT_PAL_AW-1:0] cur_pal_base;

    // address stage to fetch
    logic       adr_valid, adr_ready;
    addr_t      word_addr;
    logic [4:0] bit_off;
    coord_t     adr_x, adr_y;

    // fetch to colour resolve
    logic    fld_valid;
    colour_t field;
    coord_t  fld_x, fld_y;

    blit_rect_walk u_walk (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .start_x(start_x), .start_y(start_y), .src_x(src_x), .src_y(src_y),
        .width(width), .height(height), .scale_x(scale_x), .scale_y(scale_y),
        .mirror_x(mirror_x), .mirror_y(mirror_y),
        .sheet_base(sheet_base), .sheet_width(sheet_width),
        .depth(depth), .pal_base(pal_base),
        .pix_valid(pix_valid), .pix_ready(pix_ready),
        .sheet_x(sheet_x), .sheet_y(sheet_y),
        .screen_x(screen_x), .screen_y(screen_y),
        .cur_sheet_base(cur_sheet_base), .cur_sheet_width(cur_sheet_width),
        .cur_depth(cur_depth), .cur_pal_base(cur_pal_base)
    );

    blit_addr_calc u_addr (
        .clk(clk), .rst(rst),
        .pix_valid(pix_valid), .pix_ready(pix_ready),
        .sheet_x(sheet_x), .sheet_y(sheet_y),
        .screen_x(screen_x), .screen_y(screen_y),
        .sheet_base(cur_sheet_base), .sheet_width(cur_sheet_width), .depth(cur_depth),
        .adr_valid(adr_valid), .adr_ready(adr_ready),
        .word_addr(word_addr), .bit_off(bit_off), .out_x(adr_x), .out_y(adr_y)
    );

    blit_pixel_fetch u_fetch (
        .clk(clk), .rst(rst),
        .adr_valid(adr_valid), .adr_ready(adr_ready),
        .word_addr(word_addr), .bit_off(bit_off), .depth(cur_depth),
        .in_x(adr_x), .in_y(adr_y),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .fld_valid(fld_valid), .field(field), .fld_x(fld_x), .fld_y(fld_y)
    );

    blit_colour_resolve u_colour (
        .clk(clk), .rst(rst),
        .fld_valid(fld_valid), .field(field), .fld_x(fld_x), .fld_y(fld_y),
        .depth(cur_depth), .pal_base(cur_pal_base),
        .pal_addr(pal_addr), .pal_data(pal_data),
        .fb_x(fb_x), .fb_y(fb_y), .fb_colour(fb_colour), .fb_write(fb_write)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f blit_top.f --top-module blit_tb -o blit_sim \
    && ./obj_dir/blit_sim | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/blit_stim.txt
# M word_index data, P palette_index colour, all values hex
# C start_x start_y src_x src_y width height scale_x scale_y mirror_x mirror_y sheet_base sheet_width depth pal_base write_count
M 0 10001001
M 1 10021003
M 2 10041005
M 3 10061007
M 4 10081009
M 5 100a100b
M 6 100c100d
M 7 100e100f
M 10 1b2d4e87
M 11 c3a596f0
M 12 0f1e2d3c
M 13 4b5a6978
P 20 7c00
P 21 03e0
P 30 001f
P 31 7fff
P 32 4210
P 33 2108
C 0a 14 0 0 4 4 1 1 0 0 0 4 10 0 10
C 00 40 3 1 6 2 1 1 0 0 40 10 1 20 c
C 08 40 1 0 5 2 1 1 0 0 40 8 2 30 a
C 10 40 2 1 4 2 1 1 0 0 40 8 4 100 8
C 18 40 1 0 3 3 1 1 0 0 40 4 8 0 9
C 20 00 1 1 6 6 3 3 0 0 0 4 10 0 24
C 30 00 0 0 2 2 fffe fffe 0 0 0 4 10 0 4
C 00 60 0 0 3 2 1 1 1 0 0 4 10 0 6
C 08 60 1 1 3 2 1 1 0 1 0 4 10 0 6
C 10 60 0 2 4 2 1 1 1 1 0 4 10 0 8
C 20 60 0 0 6 3 2 ffff 1 0 40 8 4 100 12

//--- tb/blit_tb.sv
`timescale 1ns/100ps
`include "blit_defines.svh"

module blit_tb import blit_pkg::*; ();

    logic clk = 1'b0;
    logic rst;
    logic cmd_valid, cmd_ready;
    coord_t start_x, start_y, src_x, src_y, width, height, scale_x, scale_y;
    logic mirror_x, mirror_y;
    addr_t sheet_base;
    coord_t sheet_width;
    ct_depth_t depth;
    logic [`BLIT_PAL_AW-1:0] pal_base, pal_addr;
    addr_t araddr;
    logic arvalid, arready, rvalid, rready;
    logic [`BLIT_DATA_W-1:0] rdata;
    colour_t pal_data, fb_colour;
    coord_t fb_x, fb_y;
    logic fb_write;

    typedef enum {BUS_IDLE, BUS_AR_WAIT, BUS_AR_DONE, BUS_R_WAIT, BUS_R_VALID} bus_state_t;

    logic [31:0] sheet_mem [0:255];
    colour_t palette [0:511];
    // command table columns are start_x start_y src_x src_y width height scale_x scale_y
    // mirror_x mirror_y sheet_base sheet_width depth pal_base write_count
    logic [31:0] cmd_tab [0:15][0:14];
    int num_cmds = 0;
    coord_t exp_x[$], exp_y[$];
    colour_t exp_c[$];
    int writes_seen, cycles = 0, cycle_limit = 200;
    int coord_errors = 0, colour_errors = 0, flag_errors = 0, other_errors = 0;
    logic [31:0] lfsr = 32'h6983_bc3c;
    bus_state_t bus_state;
    int wait_cnt;
    addr_t rd_addr;
    logic r_taken = 1'b0;
    logic [8:0] pal_addr_q;

    blit_top dut (.*);

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_delay();
        int d;
        d = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            d = d * 2 + int'(lfsr[0]);
        end
        return d;
    endfunction

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            coord_errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_colour(input string name, input colour_t got, input colour_t exp);
        if (got !== exp) begin
            colour_errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic load_stim();
        int fd, c, i;
        logic [31:0] a, d;
        string line;
        byte tag;
        for (i = 0; i < 256; i++) sheet_mem[i] = {16'(i) ^ 16'h5a5a, 16'(i * 3)};
        for (i = 0; i < 512; i++) palette[i] = 16'h4000 ^ 16'(i * 7 + 3);
        fd = $fopen("tb/blit_stim.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the stimulus file tb/blit_stim.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            tag = line.getc(0);
            if (tag == "M" && $sscanf(line, "M %h %h", a, d) == 2) begin
                sheet_mem[a[7:0]] = d;
            end else if (tag == "P" && $sscanf(line, "P %h %h", a, d) == 2) begin
                palette[a[8:0]] = d[15:0];
            end else if (tag == "C") begin
                c = num_cmds;
                if ($sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        cmd_tab[c][0], cmd_tab[c][1], cmd_tab[c][2], cmd_tab[c][3],
                        cmd_tab[c][4], cmd_tab[c][5], cmd_tab[c][6], cmd_tab[c][7],
                        cmd_tab[c][8], cmd_tab[c][9], cmd_tab[c][10], cmd_tab[c][11],
                        cmd_tab[c][12], cmd_tab[c][13], cmd_tab[c][14]) == 15) begin
                    cycle_limit += cmd_tab[c][4] * cmd_tab[c][5] * 12;
                    num_cmds++;
                end
            end
        end
        $fclose(fd);
    endtask

    // expected writes from the coordinate, address and packing rules
    task automatic build_expected(input int n);
        int i, j, k, b, p, sx, sy, w, h, dep, sc_x, sc_y, base_w, pal_b;
        logic [31:0] word;
        colour_t fld;
        w = cmd_tab[n][4];
        h = cmd_tab[n][5];
        sc_x = $signed(cmd_tab[n][6][15:0]);
        sc_y = $signed(cmd_tab[n][7][15:0]);
        dep = cmd_tab[n][12];
        base_w = cmd_tab[n][10] / 4;
        pal_b = cmd_tab[n][13];
        for (j = 0; j < h; j++) begin
            for (i = 0; i < w; i++) begin
                sx = int'(cmd_tab[n][2]) + ((sc_x > 0) ? i / sc_x : i * (0 - sc_x));
                sy = int'(cmd_tab[n][3]) + ((sc_y > 0) ? j / sc_y : j * (0 - sc_y));
                p = sy * int'(cmd_tab[n][11]) + sx;
                fld = '0;
                for (k = 0; k < dep; k++) begin  // one sheet bit at a time from the msb
                    b = p * dep + k;
                    word = sheet_mem[8'(base_w + b / 32)];
                    fld = {fld[14:0], word[31 - b % 32]};
                end
                exp_x.push_back(coord_t'(cmd_tab[n][8][0] ?
                    int'(cmd_tab[n][0]) + w - 1 - i : int'(cmd_tab[n][0]) + i));
                exp_y.push_back(coord_t'(cmd_tab[n][9][0] ?
                    int'(cmd_tab[n][1]) + h - 1 - j : int'(cmd_tab[n][1]) + j));
                exp_c.push_back((dep == 16) ? fld : palette[9'(pal_b + int'(fld))]);
            end
        end
        if (w * h != int'(cmd_tab[n][14])) begin
            other_errors++;
            $display("command %0d: file expects %0d writes but the rectangle has %0d",
                     n, cmd_tab[n][14], w * h);
        end
    endtask

    task automatic run_command(input int n);
        build_expected(n);
        writes_seen = 0;
        while (!cmd_ready) @(negedge clk);
        start_x = cmd_tab[n][0][15:0];
        start_y = cmd_tab[n][1][15:0];
        src_x = cmd_tab[n][2][15:0];
        src_y = cmd_tab[n][3][15:0];
        width = cmd_tab[n][4][15:0];
        height = cmd_tab[n][5][15:0];
        scale_x = cmd_tab[n][6][15:0];
        scale_y = cmd_tab[n][7][15:0];
        mirror_x = cmd_tab[n][8][0];
        mirror_y = cmd_tab[n][9][0];
        sheet_base = cmd_tab[n][10];
        sheet_width = cmd_tab[n][11][15:0];
        depth = ct_depth_t'(cmd_tab[n][12][4:0]);
        pal_base = cmd_tab[n][13][15:0];
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        check_flag("cmd_ready", cmd_ready, 1'b0);  // busy right after accept
        while (writes_seen < int'(cmd_tab[n][14])) @(negedge clk);
        check_flag("cmd_ready", cmd_ready, 1'b1);
    endtask

    // a read beat is taken on a rising edge with rvalid and rready high
    always @(posedge clk) begin
        r_taken = rvalid && rready;
    end

    // AXI-lite read responder with random arready and rvalid delays
    always @(negedge clk) begin
        if (rst) begin
            arready = 1'b0;
            rvalid = 1'b0;
            rdata = '0;
            bus_state = BUS_IDLE;
        end else begin
            if (bus_state == BUS_R_VALID && r_taken) begin  // data held until rready
                rvalid = 1'b0;
                bus_state = BUS_IDLE;
            end
            if (bus_state == BUS_AR_DONE) begin
                arready = 1'b0;
                wait_cnt = rand_delay();
                bus_state = BUS_R_WAIT;
            end
            if (bus_state == BUS_IDLE && arvalid) begin
                wait_cnt = rand_delay();
                bus_state = BUS_AR_WAIT;
            end
            if (bus_state == BUS_AR_WAIT) begin
                if (wait_cnt == 0) begin
                    arready = 1'b1;
                    rd_addr = araddr;
                    bus_state = BUS_AR_DONE;
                end else begin
                    wait_cnt--;
                end
            end
            if (bus_state == BUS_R_WAIT) begin
                if (wait_cnt == 0) begin
                    rvalid = 1'b1;
                    rdata = sheet_mem[rd_addr[9:2]];
                    bus_state = BUS_R_VALID;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // palette answers one cycle after the address
    always @(negedge clk) begin
        pal_data = palette[pal_addr_q];
        pal_addr_q = pal_addr[8:0];
    end

    always @(posedge clk) begin
        if (!rst && fb_write) begin
            writes_seen++;
            if (exp_x.size() == 0) begin
                other_errors++;
                $display("framebuffer write at %0t with no pixel expected", $time);
            end else begin
                check_coord("fb_x", fb_x, exp_x.pop_front());
                check_coord("fb_y", fb_y, exp_y.pop_front());
                check_colour("fb_colour", fb_colour, exp_c.pop_front());
            end
        end
    end

    function automatic void print_counts();
        $display("errors: coord %0d, colour %0d, flag %0d, other %0d",
                 coord_errors, colour_errors, flag_errors, other_errors);
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: no finish within %0d cycles", cycle_limit);
            print_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int n;
        rst = 1'b1;
        cmd_valid = 1'b0;
        {start_x, start_y, src_x, src_y, width, height} = '0;
        scale_x = 16'd1;
        scale_y = 16'd1;
        {mirror_x, mirror_y} = 2'b00;
        sheet_base = '0;
        sheet_width = '0;
        depth = CT_16;
        pal_base = '0;
        {arready, rvalid, rdata} = '0;
        pal_data = '0;
        pal_addr_q = '0;
        load_stim();
        repeat (2) begin
            @(negedge clk);
            check_flag("cmd_ready", cmd_ready, 1'b0);
            check_flag("fb_write", fb_write, 1'b0);
        end
        rst = 1'b0;
        for (n = 0; n < num_cmds; n++) run_command(n);
        repeat (20) @(negedge clk);  // watch for stray writes
        if (exp_x.size() != 0) begin
            other_errors++;
            $display("%0d expected pixels were never written", exp_x.size());
        end
        print_counts();
        if (coord_errors + colour_errors + flag_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
